// ==== list.f ====
verilog/u2_ctrl_pkg.sv
verilog/wb_settings_slave.sv
verilog/control_regs.sv
verilog/vita_timer.sv
verilog/status_readback.sv
verilog/u2_ctrl_core.sv
verification/tb_u2_ctrl_core.sv

// ==== verification/tb_u2_ctrl_core.sv ====
// Self-checking testbench for the radio control core. Drives the Wishbone
// port and board inputs, then checks pins and readback words against the map.

`timescale 1ns/1ps

module tb_u2_ctrl_core;
   import u2_ctrl_pkg::*;

   // Six short tests take well under 1000 cycles
   localparam int TIMEOUT_CYCLES = 4000;
   localparam int ACK_LIMIT      = 20;

   logic        dsp_clk = 1'b0;
   logic        wb_rst;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   logic        pps_i;
   logic        sim_mode;
   logic [3:0]  clock_divider;
   logic        clk_status;
   logic        serdes_link_up;
   logic        phy_int_n;
   logic        clock_ready;
   logic [1:0]  clk_en;
   logic [1:0]  clk_sel;
   logic        ser_enable;
   logic        ser_prbsen;
   logic        ser_loopen;
   logic        ser_rx_en;
   logic        adc_oe_a;
   logic        adc_on_a;
   logic        adc_oe_b;
   logic        adc_on_b;
   logic        phy_reset_n;
   logic [7:0]  leds;

   int          cycle_cnt = 0;
   int          errors = 0;
   int          tests_run = 0;
   int          tests_failed = 0;
   int          test_err_base = 0;
   int          pps_pulses = 0;
   int          last_ack_cycle = 0;
   string       test_name = "startup";
   logic [31:0] rng_state = 32'h856d;

   u2_ctrl_core DUT (
      .dsp_clk(dsp_clk), .wb_rst(wb_rst), .wb_req_i(wb_req), .wb_rsp_o(wb_rsp),
      .pps_i(pps_i), .sim_mode_i(sim_mode), .clock_divider_i(clock_divider),
      .clk_status_i(clk_status), .serdes_link_up_i(serdes_link_up),
      .phy_int_n_i(phy_int_n), .clock_ready_o(clock_ready), .clk_en_o(clk_en),
      .clk_sel_o(clk_sel), .ser_enable_o(ser_enable), .ser_prbsen_o(ser_prbsen),
      .ser_loopen_o(ser_loopen), .ser_rx_en_o(ser_rx_en), .adc_oe_a_o(adc_oe_a),
      .adc_on_a_o(adc_on_a), .adc_oe_b_o(adc_oe_b), .adc_on_b_o(adc_on_b),
      .phy_reset_n_o(phy_reset_n), .leds_o(leds)
   );

   always #5 dsp_clk = ~dsp_clk;

   // Cycle count and run limit
   always @(posedge dsp_clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout after %0d cycles while running %s", cycle_cnt, test_name);
         $display("TEST FAIL");
         $finish;
      end
   end

   always @(posedge dsp_clk) begin
      if (!wb_rst && DUT.pps_int) begin
         pps_pulses <= pps_pulses + 1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Protocol checks

   a_pps_int_single : assert property (
      @(posedge dsp_clk) disable iff (wb_rst) DUT.pps_int |=> !DUT.pps_int
   ) else begin
      $display("pps_int stayed high for more than one cycle");
      errors++;
   end

   a_ack_after_req : assert property (
      @(posedge dsp_clk) disable iff (wb_rst) wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb)
   ) else begin
      $display("ack raised without a preceding request");
      errors++;
   end

   a_strobe_with_ack : assert property (
      @(posedge dsp_clk) disable iff (wb_rst) DUT.set_bus.strobe |-> wb_rsp.ack
   ) else begin
      $display("settings strobe raised outside a write ack");
      errors++;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Helpers

   function automatic logic [31:0] next_rand();
      rng_state = rng_state ^ (rng_state << 13);
      rng_state = rng_state ^ (rng_state >> 17);
      rng_state = rng_state ^ (rng_state << 5);
      return rng_state;
   endfunction

   function automatic logic [15:0] set_adr(input logic [7:0] addr);
      return SET_WIN_BASE | {6'd0, addr, 2'b00};
   endfunction

   function automatic logic [15:0] rb_adr(input logic [3:0] idx);
      return RB_WIN_BASE | {10'd0, idx, 2'b00};
   endfunction

   // Source bit 1 shows hardware, 0 shows software
   function automatic logic [7:0] led_mix(input logic [7:0] src, input logic [7:0] sw,
                                          input logic cs, input logic lu);
      logic [7:0] hw;
      logic [7:0] mix;
      hw = 8'd0;
      hw[1] = lu;
      hw[2] = cs;
      for (int i = 0; i < 8; i++) begin
         mix[i] = src[i] ? hw[i] : sw[i];
      end
      return mix;
   endfunction

   task automatic check_value(input logic [63:0] expected, input logic [63:0] actual);
      assert (expected === actual) else begin
         $display("[ERROR] %s expected %h actual %h", test_name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_range(input logic [63:0] lo, input logic [63:0] hi,
                              input logic [63:0] actual);
      assert (actual >= lo && actual <= hi) else begin
         $display("[ERROR] %s expected %0d..%0d actual %0d", test_name, lo, hi, actual);
         errors++;
      end
   endtask

   // One classic cycle, held until ack, stb dropped on the next edge
   task automatic bus_access(input logic we, input logic [15:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
      wb_req_t req;
      int      wait_cnt;
      req     = '0;
      req.cyc = 1'b1;
      req.stb = 1'b1;
      req.we  = we;
      req.adr = adr;
      req.sel = 4'hF;
      req.dat = wdat;
      wait_cnt = 0;
      @(posedge dsp_clk);
      wb_req <= req;
      do begin
         @(negedge dsp_clk);
         wait_cnt++;
      end while (!wb_rsp.ack && wait_cnt < ACK_LIMIT);
      if (!wb_rsp.ack) begin
         $display("%s: no ack for address %h", test_name, adr);
         errors++;
      end
      rdat = wb_rsp.dat;
      last_ack_cycle = cycle_cnt;
      @(posedge dsp_clk);
      wb_req <= '0;
   endtask

   task automatic wb_write(input logic [15:0] adr, input logic [31:0] dat);
      logic [31:0] unused;
      bus_access(1'b1, adr, dat, unused);
   endtask

   task automatic wb_read(input logic [15:0] adr, output logic [31:0] dat);
      bus_access(1'b0, adr, 32'd0, dat);
   endtask

   task automatic read_time(output logic [63:0] t);
      logic [31:0] hi;
      logic [31:0] lo;
      wb_read(rb_adr(RB_TIME_HI), hi);
      wb_read(rb_adr(RB_TIME_LO), lo);
      t = {hi, lo};
   endtask

   task automatic start_test(input string name);
      test_name = name;
      test_err_base = errors;
   endtask

   task automatic end_test();
      tests_run++;
      if (errors != test_err_base) begin
         tests_failed++;
         $display("%s: failed, %0d errors", test_name, errors - test_err_base);
      end else begin
         $display("%s: ok", test_name);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Tests

   initial begin
      logic [31:0] d;
      logic [31:0] sw;
      logic [31:0] src;
      logic [31:0] c1;
      logic [31:0] c2;
      logic [63:0] t_load;
      logic [63:0] t_pps;
      logic [63:0] t_now;
      logic [31:0] irq_exp;
      logic [31:0] straps_exp;
      int          k1;
      int          pps_before;

      wb_rst         = 1'b1;
      wb_req         = '0;
      pps_i          = 1'b0;
      sim_mode       = 1'b1;
      clock_divider  = 4'd5;
      clk_status     = 1'b1;
      serdes_link_up = 1'b1;
      phy_int_n      = 1'b1;
      repeat (10) @(posedge dsp_clk);
      wb_rst <= 1'b0;

      start_test("reset_state");
      @(negedge dsp_clk);
      check_value(16'h0, {clock_ready, clk_en, clk_sel, ser_enable, ser_prbsen, ser_loopen,
                          ser_rx_en, adc_oe_a, adc_on_a, adc_oe_b, adc_on_b});
      check_value(1'b1, phy_reset_n);
      check_value(led_mix(8'b0001_1110, 8'd0, clk_status, serdes_link_up), leds);
      wb_read(rb_adr(RB_COMPAT), d);
      check_value(32'd2, d);
      straps_exp = 32'd0;
      straps_exp[31] = sim_mode;
      straps_exp[3:0] = clock_divider;
      wb_read(rb_adr(RB_STRAPS), d);
      check_value(straps_exp, d);
      end_test();

      start_test("control_regs");
      repeat (4) begin
         d = next_rand();
         wb_write(set_adr(SR_CLK), d);
         @(negedge dsp_clk);
         check_value(d[4:0], {clock_ready, clk_en, clk_sel});
         d = next_rand();
         wb_write(set_adr(SR_SER), d);
         @(negedge dsp_clk);
         check_value(d[3:0], {ser_enable, ser_prbsen, ser_loopen, ser_rx_en});
         d = next_rand();
         wb_write(set_adr(SR_ADC), d);
         @(negedge dsp_clk);
         check_value(d[3:0], {adc_oe_a, adc_on_a, adc_oe_b, adc_on_b});
         d = next_rand();
         wb_write(set_adr(SR_PHY), d);
         @(negedge dsp_clk);
         check_value(!d[0], phy_reset_n);
      end
      end_test();

      start_test("led_mix");
      repeat (6) begin
         sw  = next_rand();
         src = next_rand();
         d   = next_rand();
         wb_write(set_adr(SR_LED_SW), sw);
         wb_write(set_adr(SR_LED_SRC), src);
         @(posedge dsp_clk);
         clk_status     <= d[0];
         serdes_link_up <= d[1];
         @(negedge dsp_clk);
         check_value(led_mix(src[7:0], sw[7:0], d[0], d[1]), leds);
      end
      end_test();

      start_test("vita_load");
      // Low words kept clear of a carry between the two reads
      t_load = {next_rand(), next_rand() & 32'h7FFF_FFFF};
      wb_write(set_adr(SR_TIME64), t_load[63:32]);
      wb_write(set_adr(SR_TIME64 + 8'd1), t_load[31:0]);
      wb_write(set_adr(SR_TIME64 + 8'd2), 32'd1);
      read_time(t_now);
      check_range(1, 10, t_now - t_load);
      t_pps = {t_load[63:32] ^ 32'h8000_0000, next_rand() & 32'h7FFF_FFFF};
      wb_write(set_adr(SR_TIME64), t_pps[63:32]);
      wb_write(set_adr(SR_TIME64 + 8'd1), t_pps[31:0]);
      wb_write(set_adr(SR_TIME64 + 8'd2), 32'd0);
      read_time(t_now);
      // Still counting from the first load
      check_range(1, 100, t_now - t_load);
      @(posedge dsp_clk);
      pps_i <= 1'b1;
      repeat (3) @(posedge dsp_clk);
      pps_i <= 1'b0;
      read_time(t_now);
      check_range(1, 10, t_now - t_pps);
      end_test();

      start_test("cycles_unmapped");
      wb_read(rb_adr(RB_CYCLES), c1);
      k1 = last_ack_cycle;
      repeat (7) @(posedge dsp_clk);
      wb_read(rb_adr(RB_CYCLES), c2);
      check_range(last_ack_cycle - k1, 32'hFFFF_FFFF, c2 - c1);
      wb_read(rb_adr(4'd9), d);
      check_value(32'd0, d);
      wb_write(16'h1000, next_rand());
      wb_read(16'h5000, d);
      check_value(32'd0, d);
      end_test();

      start_test("irq_word");
      repeat (4) begin
         d = next_rand();
         @(posedge dsp_clk);
         phy_int_n      <= d[0];
         serdes_link_up <= d[1];
         clk_status     <= d[2];
         irq_exp = 32'd0;
         irq_exp[4]  = d[0];
         irq_exp[10] = d[1];
         irq_exp[11] = d[2];
         wb_read(rb_adr(RB_IRQ), c1);
         check_value(irq_exp, c1);
      end
      pps_before = pps_pulses;
      @(posedge dsp_clk);
      pps_i <= 1'b1;
      repeat (4) @(posedge dsp_clk);
      pps_i <= 1'b0;
      repeat (6) @(posedge dsp_clk);
      check_value(1, pps_pulses - pps_before);
      end_test();

      $display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0 && tests_failed == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

// ==== verilog/control_regs.sv ====
// Board control registers loaded from the settings bus: clock generator,
// SERDES, ADC, PHY reset and the LED software and source registers.

`timescale 1ns/1ps

module control_regs #(
   parameter logic [7:0] LED_SRC_RESET = 8'b0001_1110
) (
   input  logic                          dsp_clk,
   input  logic                          wb_rst,
   input  u2_ctrl_pkg::settings_write_t  set_i,
   input  logic                          clk_status_i,
   input  logic                          serdes_link_up_i,
   output u2_ctrl_pkg::radio_ctrl_t      ctrl_o,
   output logic [7:0]                    leds_o
);
   import u2_ctrl_pkg::*;

   logic [4:0] clk_q;
   logic [3:0] ser_q;
   logic [3:0] adc_q;
   logic       phy_q;
   logic [7:0] led_sw_q;
   logic [7:0] led_src_q;
   logic [7:0] led_hw;

   ////////////////////////////////////////////////////////////////////////////
   // Register file

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         clk_q     <= '0;
         ser_q     <= '0;
         adc_q     <= '0;
         phy_q     <= 1'b0;
         led_sw_q  <= '0;
         led_src_q <= LED_SRC_RESET;
      end else if (set_i.strobe) begin
         case (set_i.addr)
            SR_CLK:     clk_q     <= set_i.data[4:0];
            SR_SER:     ser_q     <= set_i.data[3:0];
            SR_ADC:     adc_q     <= set_i.data[3:0];
            SR_LED_SW:  led_sw_q  <= set_i.data[7:0];
            SR_PHY:     phy_q     <= set_i.data[0];
            SR_LED_SRC: led_src_q <= set_i.data[7:0];
            default: ;
         endcase
      end
   end

   // Clock word is {ready, en[1:0], sel[1:0]}
   assign ctrl_o.clock_ready = clk_q[4];
   assign ctrl_o.clk_en      = clk_q[3:2];
   assign ctrl_o.clk_sel     = clk_q[1:0];

   assign ctrl_o.ser_enable  = ser_q[3];
   assign ctrl_o.ser_prbsen  = ser_q[2];
   assign ctrl_o.ser_loopen  = ser_q[1];
   assign ctrl_o.ser_rx_en   = ser_q[0];

   assign ctrl_o.adc_oe_a    = adc_q[3];
   assign ctrl_o.adc_on_a    = adc_q[2];
   assign ctrl_o.adc_oe_b    = adc_q[1];
   assign ctrl_o.adc_on_b    = adc_q[0];

   assign ctrl_o.phy_reset   = phy_q;

   ////////////////////////////////////////////////////////////////////////////
   // LED mix
   // Source bit 1 picks the hardware bit, 0 picks software

   assign led_hw = {5'b0, clk_status_i, serdes_link_up_i, 1'b0};
   assign leds_o = (led_src_q & led_hw) | (~led_src_q & led_sw_q);

   // Register contents move only one edge after a settings strobe
   a_change_needs_strobe : assert property (
      @(posedge dsp_clk) disable iff (wb_rst)
      !$stable({clk_q, ser_q, adc_q, phy_q, led_sw_q, led_src_q}) |->
         $past(set_i.strobe)
   ) else $error("control register changed without a settings strobe");

endmodule

// ==== verilog/status_readback.sv ====
// Readback side of the control core: free-running cycle counter and the
// 16-word mux addressed by the Wishbone slave.

`timescale 1ns/1ps

module status_readback #(
   parameter logic [31:0] COMPAT_NUM = 32'd2
) (
   input  logic                        dsp_clk,
   input  logic                        wb_rst,
   input  logic [3:0]                  rb_index_i,
   input  logic [63:0]                 vita_time_i,
   input  logic                        sim_mode_i,
   input  logic [3:0]                  clock_divider_i,
   input  logic [31:0]                 irq_i,
   output logic [u2_ctrl_pkg::DW-1:0]  rb_word_o
);
   import u2_ctrl_pkg::*;

   logic [31:0] cycle_q;

   // Cycles since reset
   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         cycle_q <= '0;
      end else begin
         cycle_q <= cycle_q + 32'd1;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Word select

   always_comb begin
      case (rb_index_i)
         RB_TIME_HI: rb_word_o = vita_time_i[63:32];
         RB_TIME_LO: rb_word_o = vita_time_i[31:0];
         RB_COMPAT:  rb_word_o = COMPAT_NUM;
         RB_CYCLES:  rb_word_o = cycle_q;
         // Strap pins, sim mode on top
         RB_STRAPS:  rb_word_o = {sim_mode_i, 27'd0, clock_divider_i};
         RB_IRQ:     rb_word_o = irq_i;
         default:    rb_word_o = '0;
      endcase
   end

endmodule

// ==== verilog/u2_ctrl_core.sv ====
// Top of the radio control core. Connects the Wishbone slave, control
// registers, VITA timer and readback mux to the board pins.

`timescale 1ns/1ps

module u2_ctrl_core #(
   parameter logic [7:0]  LED_SRC_RESET = 8'b0001_1110,
   parameter logic [7:0]  TIME_BASE     = u2_ctrl_pkg::SR_TIME64,
   parameter logic [31:0] COMPAT_NUM    = 32'd2
) (
   input  logic                  dsp_clk,
   input  logic                  wb_rst,
   input  u2_ctrl_pkg::wb_req_t  wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t  wb_rsp_o,
   input  logic                  pps_i,
   input  logic                  sim_mode_i,
   input  logic [3:0]            clock_divider_i,
   input  logic                  clk_status_i,
   input  logic                  serdes_link_up_i,
   input  logic                  phy_int_n_i,

   // Clock generator
   output logic                  clock_ready_o,
   output logic [1:0]            clk_en_o,
   output logic [1:0]            clk_sel_o,

   // SERDES
   output logic                  ser_enable_o,
   output logic                  ser_prbsen_o,
   output logic                  ser_loopen_o,
   output logic                  ser_rx_en_o,

   // ADC
   output logic                  adc_oe_a_o,
   output logic                  adc_on_a_o,
   output logic                  adc_oe_b_o,
   output logic                  adc_on_b_o,

   output logic                  phy_reset_n_o,
   output logic [7:0]            leds_o
);
   import u2_ctrl_pkg::*;

   settings_write_t set_bus;
   radio_ctrl_t     ctrl;
   logic [3:0]      rb_index;
   logic [DW-1:0]   rb_word;
   logic [63:0]     vita_time;
   logic            pps_int;
   logic [31:0]     irq_word;

   wb_settings_slave u_slave (
      .dsp_clk    (dsp_clk),
      .wb_rst     (wb_rst),
      .wb_req_i   (wb_req_i),
      .wb_rsp_o   (wb_rsp_o),
      .set_o      (set_bus),
      .rb_index_o (rb_index),
      .rb_word_i  (rb_word)
   );

   control_regs #(.LED_SRC_RESET(LED_SRC_RESET)) u_regs (
      .dsp_clk          (dsp_clk),
      .wb_rst           (wb_rst),
      .set_i            (set_bus),
      .clk_status_i     (clk_status_i),
      .serdes_link_up_i (serdes_link_up_i),
      .ctrl_o           (ctrl),
      .leds_o           (leds_o)
   );

   vita_timer #(.BASE(TIME_BASE)) u_timer (
      .dsp_clk     (dsp_clk),
      .wb_rst      (wb_rst),
      .set_i       (set_bus),
      .pps_i       (pps_i),
      .vita_time_o (vita_time),
      .pps_int_o   (pps_int)
   );

   // Interrupt sources, same bit positions as the full board
   assign irq_word = {20'd0, clk_status_i, serdes_link_up_i, 2'b00,
                      pps_int, 2'b00, phy_int_n_i, 4'd0};

   status_readback #(.COMPAT_NUM(COMPAT_NUM)) u_readback (
      .dsp_clk         (dsp_clk),
      .wb_rst          (wb_rst),
      .rb_index_i      (rb_index),
      .vita_time_i     (vita_time),
      .sim_mode_i      (sim_mode_i),
      .clock_divider_i (clock_divider_i),
      .irq_i           (irq_word),
      .rb_word_o       (rb_word)
   );

   ////////////////////////////////////////////////////////////////////////////
   // Pins

   assign clock_ready_o = ctrl.clock_ready;
   assign clk_en_o      = ctrl.clk_en;
   assign clk_sel_o     = ctrl.clk_sel;
   assign ser_enable_o  = ctrl.ser_enable;
   assign ser_prbsen_o  = ctrl.ser_prbsen;
   assign ser_loopen_o  = ctrl.ser_loopen;
   assign ser_rx_en_o   = ctrl.ser_rx_en;
   assign adc_oe_a_o    = ctrl.adc_oe_a;
   assign adc_on_a_o    = ctrl.adc_on_a;
   assign adc_oe_b_o    = ctrl.adc_oe_b;
   assign adc_on_b_o    = ctrl.adc_on_b;
   // PHY reset pin is active low
   assign phy_reset_n_o = ~ctrl.phy_reset;

endmodule

// ==== verilog/u2_ctrl_pkg.sv ====
// Shared bus widths, settings map, readback map and signal bundles for the
// radio control core. RTL modules import what they need from here.

package u2_ctrl_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Wishbone geometry

   localparam int DW = 32;
   localparam int AW = 16;
   localparam int SW = 4;

   // Settings window, 0x2000 to 0x23FF
   localparam logic [AW-1:0] SET_WIN_BASE = 16'h2000;
   localparam logic [AW-1:0] SET_WIN_MASK = 16'hFC00;

   // Readback window, 0x3300 to 0x33FF
   localparam logic [AW-1:0] RB_WIN_BASE = 16'h3300;
   localparam logic [AW-1:0] RB_WIN_MASK = 16'hFF00;

   ////////////////////////////////////////////////////////////////////////////
   // Settings bus addresses

   localparam logic [7:0] SR_CLK     = 8'd0;
   localparam logic [7:0] SR_SER     = 8'd1;
   localparam logic [7:0] SR_ADC     = 8'd2;
   localparam logic [7:0] SR_LED_SW  = 8'd3;
   localparam logic [7:0] SR_PHY     = 8'd4;
   localparam logic [7:0] SR_LED_SRC = 8'd8;
   // Three consecutive words: high, low, mode
   localparam logic [7:0] SR_TIME64  = 8'd192;

   // Readback word indices, all others read zero
   localparam logic [3:0] RB_TIME_HI = 4'd0;
   localparam logic [3:0] RB_TIME_LO = 4'd1;
   localparam logic [3:0] RB_COMPAT  = 4'd2;
   localparam logic [3:0] RB_CYCLES  = 4'd3;
   localparam logic [3:0] RB_STRAPS  = 4'd4;
   localparam logic [3:0] RB_IRQ     = 4'd5;

   ////////////////////////////////////////////////////////////////////////////
   // Bundles

   // Host to slave
   typedef struct packed {
      logic          cyc;
      logic          stb;
      logic          we;
      logic [AW-1:0] adr;
      logic [SW-1:0] sel;
      logic [DW-1:0] dat;
   } wb_req_t;

   // Slave to host
   typedef struct packed {
      logic          ack;
      logic [DW-1:0] dat;
   } wb_rsp_t;

   // One-cycle settings write
   typedef struct packed {
      logic        strobe;
      logic [7:0]  addr;
      logic [31:0] data;
   } settings_write_t;

   // Board control lines, active high
   typedef struct packed {
      logic       clock_ready;
      logic [1:0] clk_en;
      logic [1:0] clk_sel;
      logic       ser_enable;
      logic       ser_prbsen;
      logic       ser_loopen;
      logic       ser_rx_en;
      logic       adc_oe_a;
      logic       adc_on_a;
      logic       adc_oe_b;
      logic       adc_on_b;
      logic       phy_reset;
   } radio_ctrl_t;

endpackage

// ==== verilog/vita_timer.sv ====
// 64-bit VITA time counter. The time is loaded from the settings bus either
// at once or at the next PPS rising edge, and PPS raises a one-cycle interrupt.

`timescale 1ns/1ps

module vita_timer #(
   parameter logic [7:0] BASE = u2_ctrl_pkg::SR_TIME64
) (
   input  logic                          dsp_clk,
   input  logic                          wb_rst,
   input  u2_ctrl_pkg::settings_write_t  set_i,
   input  logic                          pps_i,
   output logic [63:0]                   vita_time_o,
   output logic                          pps_int_o
);

   localparam logic [7:0] ADDR_HI   = BASE;
   localparam logic [7:0] ADDR_LO   = BASE + 8'd1;
   localparam logic [7:0] ADDR_MODE = BASE + 8'd2;

   logic [31:0] pend_hi_q;
   logic [31:0] pend_lo_q;
   logic        pps_meta_q;
   logic        pps_sync_q;
   logic        pps_prev_q;
   logic        pps_edge;
   logic        armed_q;
   logic        mode_wr;
   logic [63:0] time_q;
   logic        pps_int_q;

   assign mode_wr  = set_i.strobe && (set_i.addr == ADDR_MODE);
   assign pps_edge = pps_sync_q & ~pps_prev_q;

   // Pending time words
   always_ff @(posedge dsp_clk) begin
      if (set_i.strobe && (set_i.addr == ADDR_HI)) begin
         pend_hi_q <= set_i.data;
      end
      if (set_i.strobe && (set_i.addr == ADDR_LO)) begin
         pend_lo_q <= set_i.data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // PPS synchronizer, counter and load control

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         pps_meta_q <= 1'b0;
         pps_sync_q <= 1'b0;
         pps_prev_q <= 1'b0;
         pps_int_q  <= 1'b0;
         armed_q    <= 1'b0;
         time_q     <= '0;
      end else begin
         pps_meta_q <= pps_i;
         pps_sync_q <= pps_meta_q;
         pps_prev_q <= pps_sync_q;
         pps_int_q  <= pps_edge;

         if (mode_wr && set_i.data[0]) begin
            // Load now
            time_q  <= {pend_hi_q, pend_lo_q};
            armed_q <= 1'b0;
         end else if (mode_wr) begin
            // Wait for the next edge, keep counting meanwhile
            armed_q <= 1'b1;
            time_q  <= time_q + 64'd1;
         end else if (armed_q && pps_edge) begin
            time_q  <= {pend_hi_q, pend_lo_q};
            armed_q <= 1'b0;
         end else begin
            time_q  <= time_q + 64'd1;
         end
      end
   end

   assign vita_time_o = time_q;
   assign pps_int_o   = pps_int_q;

   // An armed load is taken on the PPS edge and the time follows it
   a_pps_load : assert property (
      @(posedge dsp_clk) disable iff (wb_rst)
      (armed_q && pps_edge && !mode_wr) |=>
         (!armed_q && time_q == $past({pend_hi_q, pend_lo_q}))
   ) else $error("armed time load not taken at PPS edge");

endmodule

// ==== verilog/wb_settings_slave.sv ====
// Wishbone classic slave for the control core. Writes into the settings
// window become one-cycle settings strobes, reads return readback words.

`timescale 1ns/1ps

module wb_settings_slave (
   input  logic                          dsp_clk,
   input  logic                          wb_rst,
   input  u2_ctrl_pkg::wb_req_t          wb_req_i,
   output u2_ctrl_pkg::wb_rsp_t          wb_rsp_o,
   output u2_ctrl_pkg::settings_write_t  set_o,
   output logic [3:0]                    rb_index_o,
   input  logic [u2_ctrl_pkg::DW-1:0]    rb_word_i
);
   import u2_ctrl_pkg::*;

   logic          ack_q;
   logic          req_take;
   logic          set_win_hit;
   logic          rb_win_hit;
   logic          set_stb_q;
   logic [7:0]    set_addr_q;
   logic [31:0]   set_data_q;
   logic [DW-1:0] rd_dat_q;

   ////////////////////////////////////////////////////////////////////////////
   // Window decode

   assign set_win_hit = (wb_req_i.adr & SET_WIN_MASK) == SET_WIN_BASE;
   assign rb_win_hit  = (wb_req_i.adr & RB_WIN_MASK) == RB_WIN_BASE;

   // Word index into the readback mux
   assign rb_index_o = wb_req_i.adr[5:2];

   // New cycle only when no ack is pending, so stb held over the ack edge
   // does not start a second transfer
   assign req_take = wb_req_i.cyc & wb_req_i.stb & ~ack_q;

   ////////////////////////////////////////////////////////////////////////////
   // Handshake and strobe

   always_ff @(posedge dsp_clk) begin
      if (wb_rst) begin
         ack_q     <= 1'b0;
         set_stb_q <= 1'b0;
      end else begin
         ack_q     <= req_take;
         set_stb_q <= req_take & wb_req_i.we & set_win_hit;
      end
   end

   // Address, write data and read data captured with the ack
   always_ff @(posedge dsp_clk) begin
      if (req_take) begin
         set_addr_q <= wb_req_i.adr[9:2];
         set_data_q <= wb_req_i.dat;
         if (!wb_req_i.we && rb_win_hit) begin
            rd_dat_q <= rb_word_i;
         end else begin
            rd_dat_q <= '0;
         end
      end
   end

   assign wb_rsp_o.ack = ack_q;
   assign wb_rsp_o.dat = rd_dat_q;

   assign set_o.strobe = set_stb_q;
   assign set_o.addr   = set_addr_q;
   assign set_o.data   = set_data_q;

   ////////////////////////////////////////////////////////////////////////////
   // Checks

   // Single-cycle ack even while the master still holds stb
   a_ack_one_cycle : assert property (
      @(posedge dsp_clk) disable iff (wb_rst)
      wb_rsp_o.ack |=> !wb_rsp_o.ack
   ) else $error("wb ack held high for two cycles");

endmodule
